/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = eeprom_tb
FILELIST  = eeprom_ctrl.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* eeprom_ctrl.f */
rtl/eeprom_pkg.sv
rtl/eeprom_wb_slave.sv
rtl/eeprom_frame_builder.sv
rtl/eeprom_bit_engine.sv
rtl/eeprom_ctrl_top.sv
verification/eeprom_tb_assertions.sv
verification/eeprom_tb.sv

/* rtl/eeprom_bit_engine.sv */
`timescale 1ns/1ps
module eeprom_bit_engine
#(
    parameter int CLK_DIV = 4
)
(
    input  logic                     CLK,
    input  logic                     RESET,
    input  eeprom_pkg::eeprom_sym_t   sym,
    input  logic                     sym_valid,
    output logic                     sym_ready,
    output logic                     sym_done,
    output eeprom_pkg::eeprom_byte_u  sym_rdata,
    output logic                     sym_nack,
    output logic                     scl,
    output logic                     sda_low,
    input  logic                     sda_in
);

    localparam int CW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    logic                         busy;
    eeprom_pkg::eeprom_sym_kind_t kind;
    logic                         last_in;
    logic [CW-1:0]                div_cnt;
    logic [1:0]                   quarter;  // 0 low, 1 and 2 high, 3 low
    logic [3:0]                   bit_cnt;  // 8 is the ack slot
    logic [7:0]                   shreg;
    logic                         nack_bit;
    logic                         accept;
    logic                         tick;
    logic                         is_byte;
    logic                         last_bit;
    logic                         finish;

    assign sym_ready = !busy;
    assign accept    = sym_valid && !busy;
    assign tick      = busy && (div_cnt == CW'(CLK_DIV - 1));
    assign is_byte   = (kind == eeprom_pkg::SYM_BYTE_OUT) || (kind == eeprom_pkg::SYM_BYTE_IN);
    assign last_bit  = (bit_cnt == 4'd8);
    assign finish    = tick && (quarter == 2'd3) && (!is_byte || last_bit);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy     <= 1'b0;
            div_cnt  <= '0;
            quarter  <= 2'd0;
            bit_cnt  <= 4'd0;
            scl      <= 1'b1;
            sda_low  <= 1'b0;
            sym_done <= 1'b0;
        end
        else
        begin
            sym_done <= 1'b0;
            if (accept)
            begin
                busy    <= 1'b1;
                div_cnt <= '0;
                quarter <= 2'd0;
                bit_cnt <= 4'd0;
                scl     <= 1'b0;
                case (sym.kind)
                    eeprom_pkg::SYM_STOP:     sda_low <= 1'b1;
                    eeprom_pkg::SYM_BYTE_OUT: sda_low <= !sym.payload.data[7]; // msb first
                    default:                  sda_low <= 1'b0;
                endcase
            end
            else if (busy)
            begin
                div_cnt <= tick ? '0 : div_cnt + 1'b1;
                if (tick)
                begin
                    quarter <= quarter + 2'd1;
                    case (quarter)
                        2'd0: scl <= 1'b1;
                        2'd1:
                        begin
                            if (kind == eeprom_pkg::SYM_START)
                                sda_low <= 1'b1; // falls with scl high
                            else if (kind == eeprom_pkg::SYM_STOP)
                                sda_low <= 1'b0; // rises with scl high
                        end
                        2'd2:
                        begin
                            if (kind != eeprom_pkg::SYM_STOP)
                                scl <= 1'b0;
                        end
                        default:
                        begin
                            if (finish)
                            begin
                                busy     <= 1'b0;
                                sym_done <= 1'b1;
                            end
                            else
                            begin
                                bit_cnt <= bit_cnt + 4'd1;
                                if (bit_cnt == 4'd7)
                                    sda_low <= (kind == eeprom_pkg::SYM_BYTE_IN) && !last_in;
                                else
                                    sda_low <= (kind == eeprom_pkg::SYM_BYTE_OUT) && !shreg[6];
                            end
                        end
                    endcase
                end
            end
        end
    end

    // shift register, ack sample and result
    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            kind     <= sym.kind;
            last_in  <= sym.last_in;
            shreg    <= sym.payload.data;
            nack_bit <= 1'b0;
        end
        else if (tick)
        begin
            if (quarter == 2'd1) // mid-high sample point
            begin
                if (kind == eeprom_pkg::SYM_BYTE_IN && !last_bit)
                    shreg <= {shreg[6:0], sda_in};
                else if (kind == eeprom_pkg::SYM_BYTE_OUT && last_bit)
                    nack_bit <= sda_in;
            end
            else if (quarter == 2'd3 && kind == eeprom_pkg::SYM_BYTE_OUT && !last_bit)
                shreg <= {shreg[6:0], 1'b0};
        end
        if (finish)
        begin
            sym_rdata.data <= shreg;
            sym_nack       <= (kind == eeprom_pkg::SYM_BYTE_OUT) && nack_bit;
        end
    end

endmodule

/* rtl/eeprom_ctrl_top.sv */
`timescale 1ns/1ps
module eeprom_ctrl_top
#(
    parameter int CLK_DIV = 4 // CLK cycles per quarter SCL period
)
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [10:0] adr,
    input  logic [7:0]  dat_w,
    output logic [7:0]  dat_r,
    output logic        ack,
    output logic        err,
    output logic        scl,
    output logic        sda_low, // open drain, high pulls SDA to 0
    input  logic        sda_in
);

    eeprom_pkg::eeprom_req_t  req;
    logic                     req_valid;
    eeprom_pkg::eeprom_rsp_t  rsp;
    logic                     rsp_valid;
    eeprom_pkg::eeprom_sym_t  sym;
    logic                     sym_valid;
    logic                     sym_ready;
    logic                     sym_done;
    eeprom_pkg::eeprom_byte_u sym_rdata;
    logic                     sym_nack;

    eeprom_wb_slave eeprom_wb_slave_i
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .cyc       (cyc),
        .stb       (stb),
        .we        (we),
        .adr       (adr),
        .dat_w     (dat_w),
        .dat_r     (dat_r),
        .ack       (ack),
        .err       (err),
        .req       (req),
        .req_valid (req_valid),
        .rsp       (rsp),
        .rsp_valid (rsp_valid)
    );

    eeprom_frame_builder eeprom_frame_builder_i
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .req       (req),
        .req_valid (req_valid),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .sym       (sym),
        .sym_valid (sym_valid),
        .sym_ready (sym_ready),
        .sym_done  (sym_done),
        .sym_rdata (sym_rdata),
        .sym_nack  (sym_nack)
    );

    eeprom_bit_engine #(.CLK_DIV(CLK_DIV)) eeprom_bit_engine_i
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .sym       (sym),
        .sym_valid (sym_valid),
        .sym_ready (sym_ready),
        .sym_done  (sym_done),
        .sym_rdata (sym_rdata),
        .sym_nack  (sym_nack),
        .scl       (scl),
        .sda_low   (sda_low),
        .sda_in    (sda_in)
    );

endmodule

/* rtl/eeprom_frame_builder.sv */
`timescale 1ns/1ps
module eeprom_frame_builder
(
    input  logic                    CLK,
    input  logic                    RESET,
    input  eeprom_pkg::eeprom_req_t  req,
    input  logic                    req_valid,
    output eeprom_pkg::eeprom_rsp_t  rsp,
    output logic                    rsp_valid,
    output eeprom_pkg::eeprom_sym_t  sym,
    output logic                    sym_valid,
    input  logic                    sym_ready,
    input  logic                    sym_done,
    input  eeprom_pkg::eeprom_byte_u sym_rdata,
    input  logic                    sym_nack
);

    // one-hot step indices, step names the symbol waiting to go out
    localparam int S_IDLE   = 0;
    localparam int S_START  = 1;
    localparam int S_CTRLW  = 2;
    localparam int S_ADDR   = 3;
    localparam int S_WDATA  = 4;
    localparam int S_RSTART = 5;
    localparam int S_CTRLR  = 6;
    localparam int S_RDATA  = 7;
    localparam int S_STOP   = 8;
    localparam int S_WAIT   = 9; // stop in flight
    localparam int NS       = 10;

    logic [NS-1:0]            step;
    logic [NS-1:0]            cur;
    logic [NS-1:0]            nxt;
    logic                     fly_out; // engine holds a byte out
    logic                     fly_in;  // engine holds the byte in
    logic                     failed;
    logic                     abort;
    logic [7:0]               rdata_q;
    eeprom_pkg::eeprom_byte_u ctrl_byte;

    function automatic logic [NS-1:0] onehot(input int idx);
        logic [NS-1:0] v;
        v      = '0;
        v[idx] = 1'b1;
        return v;
    endfunction

    // missing ack turns the pending symbol into a stop
    assign abort     = sym_done && sym_nack && fly_out;
    assign cur       = abort ? onehot(S_STOP) : step;
    assign sym_valid = !(cur[S_IDLE] || cur[S_WAIT]);

    always_comb
    begin
        ctrl_byte.ctrl.device = eeprom_pkg::DEVICE_CODE;
        ctrl_byte.ctrl.block  = req.addr[10:8];
        ctrl_byte.ctrl.rw     = cur[S_CTRLR];
        sym.kind              = eeprom_pkg::SYM_START;
        sym.payload.data      = ctrl_byte.data;
        sym.last_in           = 1'b0;
        nxt                   = cur;
        case (1'b1)
            cur[S_START]:  nxt = onehot(S_CTRLW);
            cur[S_CTRLW]:
            begin
                sym.kind = eeprom_pkg::SYM_BYTE_OUT;
                nxt      = onehot(S_ADDR);
            end
            cur[S_ADDR]:
            begin
                sym.kind         = eeprom_pkg::SYM_BYTE_OUT;
                sym.payload.data = req.addr[7:0];
                nxt              = req.we ? onehot(S_WDATA) : onehot(S_RSTART);
            end
            cur[S_WDATA]:
            begin
                sym.kind         = eeprom_pkg::SYM_BYTE_OUT;
                sym.payload.data = req.wdata;
                nxt              = onehot(S_STOP);
            end
            cur[S_RSTART]: nxt = onehot(S_CTRLR);
            cur[S_CTRLR]:
            begin
                sym.kind = eeprom_pkg::SYM_BYTE_OUT;
                nxt      = onehot(S_RDATA);
            end
            cur[S_RDATA]:
            begin
                sym.kind    = eeprom_pkg::SYM_BYTE_IN;
                sym.last_in = 1'b1; // single byte read ends with nack
                nxt         = onehot(S_STOP);
            end
            cur[S_STOP]:
            begin
                sym.kind = eeprom_pkg::SYM_STOP;
                nxt      = onehot(S_WAIT);
            end
            default:       nxt = cur;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            step      <= onehot(S_IDLE);
            fly_out   <= 1'b0;
            fly_in    <= 1'b0;
            failed    <= 1'b0;
            rsp_valid <= 1'b0;
        end
        else
        begin
            rsp_valid <= 1'b0;
            if (abort)
                failed <= 1'b1;
            if (step[S_IDLE])
            begin
                if (req_valid && !rsp_valid) // req_valid drops one cycle after rsp
                begin
                    step   <= onehot(S_START);
                    failed <= 1'b0;
                end
            end
            else if (step[S_WAIT])
            begin
                if (sym_done)
                begin
                    step      <= onehot(S_IDLE);
                    rsp_valid <= 1'b1;
                end
            end
            else if (sym_valid && sym_ready)
            begin
                step    <= nxt;
                fly_out <= cur[S_CTRLW] | cur[S_ADDR] | cur[S_WDATA] | cur[S_CTRLR];
                fly_in  <= cur[S_RDATA];
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (sym_done && fly_in)
            rdata_q <= sym_rdata.data;
    end

    assign rsp.rdata = rdata_q;
    assign rsp.nack  = failed;

endmodule

/* rtl/eeprom_pkg.sv */
package eeprom_pkg;

    // upper nibble of every control byte for 24Cxx parts
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

    typedef enum logic [1:0]
    {
        SYM_START    = 2'd0, // start or repeated start
        SYM_BYTE_OUT = 2'd1, // 8 bits out, ack sampled from device
        SYM_BYTE_IN  = 2'd2, // 8 bits in, master ack or nack
        SYM_STOP     = 2'd3
    } eeprom_sym_kind_t;

    // control byte layout, msb first on the wire
    typedef struct packed
    {
        logic [3:0] device;
        logic [2:0] block; // addr[10:8]
        logic       rw;    // 1 = read
    } eeprom_ctrl_fields_t;

    typedef union packed
    {
        logic [7:0]          data;
        eeprom_ctrl_fields_t ctrl;
    } eeprom_byte_u;

    typedef struct packed
    {
        eeprom_sym_kind_t kind;
        eeprom_byte_u     payload;
        logic             last_in; // nack after this byte in
    } eeprom_sym_t;

    // one bus request as captured from the host
    typedef struct packed
    {
        logic        we;
        logic [10:0] addr;
        logic [7:0]  wdata;
    } eeprom_req_t;

    typedef struct packed
    {
        logic [7:0] rdata;
        logic       nack; // device did not acknowledge
    } eeprom_rsp_t;

endpackage

/* rtl/eeprom_wb_slave.sv */
`timescale 1ns/1ps
module eeprom_wb_slave
(
    input  logic                   CLK,
    input  logic                   RESET,
    input  logic                   cyc,
    input  logic                   stb,
    input  logic                   we,
    input  logic [10:0]            adr,
    input  logic [7:0]             dat_w,
    output logic [7:0]             dat_r,
    output logic                   ack,
    output logic                   err,
    output eeprom_pkg::eeprom_req_t req,
    output logic                   req_valid,
    input  eeprom_pkg::eeprom_rsp_t rsp,
    input  logic                   rsp_valid
);

    logic cyc_open;
    logic hold_off; // answered, waiting for the host to drop stb
    logic capture;

    assign cyc_open = cyc && stb;
    assign capture  = cyc_open && !req_valid && !hold_off && !rsp_valid;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            req_valid <= 1'b0;
            hold_off  <= 1'b0;
            ack       <= 1'b0;
            err       <= 1'b0;
        end
        else
        begin
            ack <= 1'b0;
            err <= 1'b0;
            if (rsp_valid)
            begin
                req_valid <= 1'b0;
                hold_off  <= 1'b1;
                ack       <= !rsp.nack;
                err       <= rsp.nack;
            end
            else if (!cyc_open)
            begin
                hold_off <= 1'b0;
            end
            else if (capture)
            begin
                req_valid <= 1'b1;
            end
        end
    end

    // request and read data registers
    always_ff @(posedge CLK)
    begin
        if (capture)
        begin
            req.we    <= we;
            req.addr  <= adr;
            req.wdata <= dat_w;
        end
        if (rsp_valid)
            dat_r <= rsp.rdata; // stale on writes, host ignores it
    end

endmodule

/* verification/eeprom_stimulus.txt */
# op (W or R), address, write data, expected read data, expected error (all hex)
# unwritten cells hold addr[7:0] ^ 5a, blocks 6 and 7 have no device
R 000 00 5a 0
R 123 00 79 0
R 5ff 00 a5 0
R 2b4 00 ee 0
W 045 c3 00 0
R 045 00 c3 0
W 3a7 19 00 0
R 3a7 00 19 0
W 600 77 00 1
R 7ff 00 00 1
R 045 00 c3 0
W 512 e8 00 0
R 512 00 e8 0
R 6aa 00 00 1
W 700 01 00 1
R 3a7 00 19 0
W 0ff 00 00 0
R 0ff 00 00 0
W 4c0 a5 00 0
R 4c0 00 a5 0
R 1c0 00 9a 0
W 1c0 3c 00 0
W 2b4 81 00 0
R 1c0 00 3c 0
R 2b4 00 81 0
R 5ff 00 a5 0

/* verification/eeprom_tb.sv */
`timescale 1ns/1ps
module eeprom_tb;

    localparam int CLK_DIV = 4;
    localparam int ST_IDLE = 0;
    localparam int ST_CTRL = 1;
    localparam int ST_ADDR = 2;
    localparam int ST_DATA = 3;
    localparam int ST_SEND = 4;

    logic        CLK;
    logic        RESET;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [10:0] adr;
    logic [7:0]  dat_w;
    logic [7:0]  dat_r;
    logic        ack;
    logic        err;
    logic        scl;
    logic        sda_low;
    logic        sda_in;

    // i2c slave model state
    logic [7:0]  mem [0:2047];
    logic        slave_rel;
    logic        prev_scl;
    logic        prev_sda;
    logic [3:0]  bcnt;
    logic [7:0]  shreg;
    logic [7:0]  tx;
    logic [2:0]  st;
    logic [2:0]  nxt_st;
    logic [2:0]  blk;
    logic [10:0] ptr;
    logic        pend_we;
    logic [7:0]  pend_data;
    logic        bus_busy;
    int          starts;
    int          stops;
    int          proto_errors;

    // stimulus table
    logic        op_we [$];
    logic [10:0] op_adr [$];
    logic [7:0]  op_wdata [$];
    logic [7:0]  op_rdata [$];
    logic        op_err [$];

    int          data_errors;
    int          resp_errors;
    int          bus_errors;
    int          cycles;
    int          limit;

    assign sda_in = !sda_low && slave_rel; // wired and

    eeprom_ctrl_top #(.CLK_DIV(CLK_DIV)) eeprom_ctrl_top_i
    (
        .CLK     (CLK),
        .RESET   (RESET),
        .cyc     (cyc),
        .stb     (stb),
        .we      (we),
        .adr     (adr),
        .dat_w   (dat_w),
        .dat_r   (dat_r),
        .ack     (ack),
        .err     (err),
        .scl     (scl),
        .sda_low (sda_low),
        .sda_in  (sda_in)
    );

    initial
    begin
        CLK = 1'b0;
    end

    always #20 CLK = ~CLK;

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit)
        begin
            $display("timeout after %0d cycles, a bus operation never finished", cycles);
            bus_errors = bus_errors + 1;
            $display("errors: data %0d, response %0d, bus %0d, protocol %0d",
                     data_errors, resp_errors, bus_errors, proto_errors);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // behavioral 24C16 slave, edges seen one CLK late
    always @(posedge CLK)
    begin
        prev_scl <= scl;
        prev_sda <= sda_in;
        if (RESET)
        begin
            st        <= 3'(ST_IDLE);
            nxt_st    <= 3'(ST_IDLE);
            slave_rel <= 1'b1;
            bcnt      <= 4'd0;
            pend_we   <= 1'b0;
            bus_busy  <= 1'b0;
        end
        else if (prev_scl && scl && prev_sda && !sda_in)
        begin
            if (!bus_busy)
                starts = starts + 1;
            bus_busy  <= 1'b1;
            st        <= 3'(ST_CTRL);
            bcnt      <= 4'd0;
            slave_rel <= 1'b1;
        end
        else if (prev_scl && scl && !prev_sda && sda_in)
        begin
            if (!bus_busy)
            begin
                $display("stop condition seen on the bus without a start");
                proto_errors = proto_errors + 1;
            end
            stops = stops + 1;
            if (pend_we)
                mem[ptr] <= pend_data; // write commits at stop
            pend_we   <= 1'b0;
            bus_busy  <= 1'b0;
            st        <= 3'(ST_IDLE);
            slave_rel <= 1'b1;
        end
        else if (!prev_scl && scl && st != 3'(ST_IDLE))
        begin
            if (bcnt < 4'd8)
                shreg <= {shreg[6:0], sda_in};
            bcnt <= bcnt + 4'd1;
        end
        else if (prev_scl && !scl && st == 3'(ST_SEND))
        begin
            if (bcnt < 4'd8)
                slave_rel <= tx[3'(4'd7 - bcnt)];
            else if (bcnt == 4'd8)
                slave_rel <= 1'b1; // master ack slot
            else
            begin
                st        <= 3'(ST_IDLE);
                slave_rel <= 1'b1;
                bcnt      <= 4'd0;
            end
        end
        else if (prev_scl && !scl && st != 3'(ST_IDLE) && bcnt == 4'd8)
        begin
            case (st)
                3'(ST_CTRL):
                begin
                    if (shreg[7:4] == 4'b1010 && shreg[3:1] <= 3'd5)
                    begin
                        slave_rel <= 1'b0;
                        blk       <= shreg[3:1];
                        nxt_st    <= shreg[0] ? 3'(ST_SEND) : 3'(ST_ADDR);
                    end
                    else
                        nxt_st <= 3'(ST_IDLE); // absent block, no ack
                end
                3'(ST_ADDR):
                begin
                    ptr       <= {blk, shreg};
                    slave_rel <= 1'b0;
                    nxt_st    <= 3'(ST_DATA);
                end
                default:
                begin
                    pend_we   <= 1'b1;
                    pend_data <= shreg;
                    slave_rel <= 1'b0;
                    nxt_st    <= 3'(ST_IDLE);
                end
            endcase
        end
        else if (prev_scl && !scl && st != 3'(ST_IDLE) && bcnt == 4'd9)
        begin
            bcnt <= 4'd0;
            st   <= nxt_st;
            if (nxt_st == 3'(ST_SEND))
            begin
                tx        <= mem[ptr];
                slave_rel <= mem[ptr][7];
            end
            else
                slave_rel <= 1'b1;
        end
    end

    task automatic load_stimulus();
        int          fd;
        int          n;
        string       line;
        byte         opc;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;
        logic [31:0] x;
        fd = $fopen("verification/eeprom_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open the stimulus file");
            bus_errors = bus_errors + 1;
            return;
        end
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%c %h %h %h %h", opc, a, d, e, x);
            if (n == 5 && (opc == "W" || opc == "R"))
            begin
                op_we.push_back(opc == "W");
                op_adr.push_back(a[10:0]);
                op_wdata.push_back(d[7:0]);
                op_rdata.push_back(e[7:0]);
                op_err.push_back(x[0]);
            end
        end
        $fclose(fd);
    endtask

    task automatic check_data(input string name, input eeprom_pkg::eeprom_byte_u got,
                              input eeprom_pkg::eeprom_byte_u exp);
        if (got.data !== exp.data)
        begin
            $display("FAIL %s got %h expected %h", name, got.data, exp.data);
            data_errors = data_errors + 1;
        end
    endtask

    task automatic check_resp(input logic got_ack, input logic got_err, input logic exp_err);
        if (got_ack !== !exp_err || got_err !== exp_err)
        begin
            $display("FAIL ack/err got %h/%h expected %h/%h", got_ack, got_err, !exp_err, exp_err);
            resp_errors = resp_errors + 1;
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            resp_errors = resp_errors + 1;
        end
    endtask

    // one wishbone classic cycle, returns at the end of the ack cycle
    task automatic bus_cycle(input logic w, input logic [10:0] a, input logic [7:0] d,
                             output logic got_ack, output logic got_err,
                             output eeprom_pkg::eeprom_byte_u got_data);
        @(posedge CLK);
        #2;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = w;
        adr   = a;
        dat_w = d;
        do
            @(negedge CLK);
        while (!(ack || err));
        got_ack       = ack;
        got_err       = err;
        got_data.data = dat_r;
        @(posedge CLK);
        #2;
        cyc = 1'b0;
        stb = 1'b0;
    endtask

    initial
    begin
        logic                     got_ack;
        logic                     got_err;
        eeprom_pkg::eeprom_byte_u got_data;
        eeprom_pkg::eeprom_byte_u exp_data;
        eeprom_pkg::eeprom_byte_u mem_data;
        RESET        = 1'b1;
        cyc          = 1'b0;
        stb          = 1'b0;
        we           = 1'b0;
        adr          = 11'd0;
        dat_w        = 8'd0;
        starts       = 0;
        stops        = 0;
        proto_errors = 0;
        data_errors  = 0;
        resp_errors  = 0;
        bus_errors   = 0;
        cycles       = 0;
        limit        = 0;
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'(i) ^ 8'h5A;
        load_stimulus();
        limit = (op_we.size() + 1) * 400 * 4 * CLK_DIV;
        repeat (2) @(posedge CLK);
        #2;
        RESET = 1'b0;
        @(negedge CLK);
        check_level("scl", scl, 1'b1);
        check_level("sda_low", sda_low, 1'b0);
        check_level("err", err, 1'b0);
        check_level("ack", ack, 1'b0);
        for (int i = 0; i < op_we.size(); i++)
        begin
            bus_cycle(op_we[i], op_adr[i], op_wdata[i], got_ack, got_err, got_data);
            check_resp(got_ack, got_err, op_err[i]);
            if (!op_err[i] && !op_we[i])
            begin
                exp_data.data = op_rdata[i];
                check_data("dat_r", got_data, exp_data);
            end
            if (!op_err[i] && op_we[i])
            begin
                mem_data.data = mem[op_adr[i]];
                exp_data.data = op_wdata[i];
                check_data("slave mem", mem_data, exp_data);
            end
            if (bus_busy)
            begin
                $display("operation %0d answered while the I2C bus was still busy", i);
                bus_errors = bus_errors + 1;
            end
        end
        if (starts != op_we.size() || stops != op_we.size())
        begin
            $display("bus saw %0d transactions opened and %0d closed", starts, stops);
            bus_errors = bus_errors + 1;
        end
        $display("errors: data %0d, response %0d, bus %0d, protocol %0d",
                 data_errors, resp_errors, bus_errors, proto_errors);
        if (data_errors + resp_errors + bus_errors + proto_errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* verification/eeprom_tb_assertions.sv */
`timescale 1ns/1ps
module eeprom_tb_assertions
(
    input logic CLK,
    input logic RESET,
    input logic cyc,
    input logic stb,
    input logic ack,
    input logic err
);

    // never both answers at once
    assert property (@(posedge CLK) disable iff (RESET) !(ack && err))
        else $error("ack and err high together");

    assert property (@(posedge CLK) disable iff (RESET) (ack || err) |-> (cyc && stb))
        else $error("answer outside an open bus cycle");

    // single cycle pulses
    assert property (@(posedge CLK) disable iff (RESET) ack |=> !ack)
        else $error("ack held longer than one cycle");

    assert property (@(posedge CLK) disable iff (RESET) err |=> !err)
        else $error("err held longer than one cycle");

endmodule

bind eeprom_ctrl_top eeprom_tb_assertions eeprom_tb_assertions_i
(
    .CLK   (CLK),
    .RESET (RESET),
    .cyc   (cyc),
    .stb   (stb),
    .ack   (ack),
    .err   (err)
);
